/* design/ctrl_cfg.svh */
`ifndef CtrlCfgSvh
`define CtrlCfgSvh

// Opcodes
`define OpRType    6'b000000
`define OpSpecial  6'b111111
`define OpLb       6'b100000
`define OpLbs      6'b100001
`define OpLh       6'b100010
`define OpLhs      6'b100011
`define OpLw       6'b100100
`define OpSb       6'b100101
`define OpSh       6'b100110
`define OpSw       6'b100111
`define OpAddi     6'b001000
`define OpAddiu    6'b001001
`define OpSlti     6'b001010
`define OpSltiu    6'b001011
`define OpAndi     6'b001100
`define OpOri      6'b001101
`define OpXori     6'b001110
`define OpLui      6'b001111
`define OpBeq      6'b110000
`define OpBgez     6'b110001
`define OpBgtz     6'b110010
`define OpBltz     6'b110011
`define OpBlez     6'b110100
`define OpBne      6'b110101
`define OpJ        6'b101000
`define OpJal      6'b101001
`define OpJr       6'b101010
`define OpJalr     6'b101011

`define FnBreak    6'b000001 // under OpSpecial
`define FnSyscall  6'b000010

`define AluB       4'd0
`define AluAddu    4'd1
`define AluAdd     4'd2
`define AluSubu    4'd3
`define AluSub     4'd4
`define AluAnd     4'd5
`define AluOr      4'd6
`define AluNor     4'd7
`define AluXor     4'd8
`define AluSltu    4'd9
`define AluSlt     4'd10
`define AluSlet    4'd11
`define AluLu      4'd12

`define RegDstRt   2'b00
`define RegDstRd   2'b01
`define RegDstRa   2'b11
`define RfSrcAlu   2'b00
`define RfSrcMdr   2'b01
`define RfSrcPc    2'b11
`define SrcAPc     1'b0
`define SrcAReg    1'b1
`define SrcBReg    2'b00
`define SrcBFour   2'b01
`define SrcBImm    2'b10
`define SrcBFourImm 2'b11
`define PcSrcPc4    3'b001
`define PcSrcBranch 3'b010
`define PcSrcJump   3'b011
`define PcSrcExc    3'b100
`define PcSrcInt    3'b101
`define PcSrcReg    3'b111

// Access size from decoder, then byte lanes
`define SizeByte   2'b00
`define SizeHalf   2'b01
`define SizeWord   2'b10
`define BeByte     4'b0001
`define BeHalf     4'b0011
`define BeWord     4'b1111

`define ExcInt      5'd0
`define ExcSyscall  5'd8
`define ExcBreak    5'd9
`define ExcIllegal  5'd10
`define ExcOverflow 5'd12

`endif

/* design/ctrlPkg.sv */
package ctrlPkg;

	typedef struct packed
	{
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rTypeT;

	typedef struct packed
	{
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} iTypeT;

	// Same instruction word, two field layouts
	typedef union packed
	{
		rTypeT r;
		iTypeT i;
	} instrWordT;

	typedef enum logic [12:0]
	{
		Fetch     = 13'h0001,
		Decode    = 13'h0002,
		MemAddr   = 13'h0004,
		MemRead   = 13'h0008,
		MemWrite  = 13'h0010,
		WriteBack = 13'h0020,
		ExecR     = 13'h0040,
		REnd      = 13'h0080,
		ExecI     = 13'h0100,
		IEnd      = 13'h0200,
		Branch    = 13'h0400,
		Jump      = 13'h0800,
		Trap      = 13'h1000
	} ctrlStateT;

	typedef enum logic [3:0]
	{
		ClsNop,
		ClsMem,
		ClsR,
		ClsI,
		ClsBranch,
		ClsJump,
		ClsSyscall,
		ClsBreak,
		ClsIllegal
	} instrClassT;

endpackage

/* design/decodeIf.sv */
interface decodeIf import ctrlPkg::*; ();

	instrClassT instrClass;
	logic [3:0] aluOp;    // for ExecR, ExecI and Branch
	logic       isStore;
	logic [1:0] memSize;
	logic       memSigned;
	logic       branchOnZero; // taken when AluZero high
	logic       jumpReg;
	logic       jumpLink;
	logic       linkRd;       // jalr writes rd, not ra

	modport decoder (output instrClass, aluOp, isStore, memSize, memSigned,
		branchOnZero, jumpReg, jumpLink, linkRd);

	modport consumer (input instrClass, aluOp, isStore, memSize, memSigned,
		branchOnZero, jumpReg, jumpLink, linkRd);

endinterface

/* design/instrDecoder.sv */
`include "ctrl_cfg.svh"

module instrDecoder import ctrlPkg::*;
(
	input instrWordT Instr,
	decodeIf.decoder dec
);

	always_comb
	begin
		dec.instrClass = ClsIllegal;
		dec.aluOp = `AluAddu;
		dec.isStore = 1'b0;
		dec.memSize = `SizeWord;
		dec.memSigned = 1'b0;
		dec.branchOnZero = 1'b0;
		dec.jumpReg = 1'b0;
		dec.jumpLink = 1'b0;
		dec.linkRd = 1'b0;
		if (Instr == '0)
			dec.instrClass = ClsNop;
		else
		begin
			case (Instr.i.op)
				`OpRType:
					if (Instr.r.funct inside {[6'd1:6'd12]})
					begin
						dec.instrClass = ClsR;
						dec.aluOp = Instr.r.funct[3:0]; // funct doubles as ALU op
					end
				`OpAddi, `OpAddiu, `OpSlti, `OpSltiu, `OpAndi, `OpOri, `OpXori, `OpLui:
				begin
					dec.instrClass = ClsI;
					case (Instr.i.op)
						`OpAddi:  dec.aluOp = `AluAdd;
						`OpAddiu: dec.aluOp = `AluAddu;
						`OpSlti:  dec.aluOp = `AluSlt;
						`OpSltiu: dec.aluOp = `AluSltu;
						`OpAndi:  dec.aluOp = `AluAnd;
						`OpOri:   dec.aluOp = `AluOr;
						`OpXori:  dec.aluOp = `AluXor;
						default:  dec.aluOp = `AluLu;
					endcase
				end
				`OpLb, `OpLbs, `OpLh, `OpLhs, `OpLw, `OpSb, `OpSh, `OpSw:
				begin
					dec.instrClass = ClsMem;
					dec.isStore = Instr.i.op inside {`OpSb, `OpSh, `OpSw};
					dec.memSigned = Instr.i.op inside {`OpLbs, `OpLhs};
					if (Instr.i.op inside {`OpLb, `OpLbs, `OpSb})
						dec.memSize = `SizeByte;
					else if (Instr.i.op inside {`OpLh, `OpLhs, `OpSh})
						dec.memSize = `SizeHalf;
				end
				`OpBeq, `OpBgez, `OpBgtz, `OpBltz, `OpBlez, `OpBne:
				begin
					dec.instrClass = ClsBranch;
					dec.branchOnZero = Instr.i.op inside {`OpBeq, `OpBgez, `OpBgtz};
					if (Instr.i.op inside {`OpBeq, `OpBne})
						dec.aluOp = `AluSubu;
					else if (Instr.i.op inside {`OpBgtz, `OpBlez})
						dec.aluOp = `AluSlet;
					else
						dec.aluOp = `AluSlt;
				end
				`OpJ, `OpJal, `OpJr, `OpJalr:
				begin
					dec.instrClass = ClsJump;
					dec.jumpReg = Instr.i.op inside {`OpJr, `OpJalr};
					dec.jumpLink = Instr.i.op inside {`OpJal, `OpJalr};
					dec.linkRd = (Instr.i.op == `OpJalr);
				end
				`OpSpecial:
					if (Instr.r.funct == `FnSyscall)
						dec.instrClass = ClsSyscall;
					else if (Instr.r.funct == `FnBreak)
						dec.instrClass = ClsBreak;
				default: ; // old coprocessor class lands here too
			endcase
		end
	end

endmodule

/* design/ctrlSequencer.sv */
module ctrlSequencer import ctrlPkg::*;
(
	input  logic      PClk,
	input  logic      Reset,
	input  logic      MemReady,
	input  logic      trapReq,
	decodeIf.consumer dec,
	output ctrlStateT state
);

	ctrlStateT nextState;

	always_ff @(posedge PClk or posedge Reset)
	begin
		if (Reset)
			state <= Fetch;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = Fetch;
		case (state)
			Fetch:
				nextState = MemReady ? Decode : Fetch;
			Decode:
			begin
				if (trapReq)
					nextState = Trap; // syscall, break, illegal
				else
				begin
					case (dec.instrClass)
						ClsMem:    nextState = MemAddr;
						ClsR:      nextState = ExecR;
						ClsI:      nextState = ExecI;
						ClsBranch: nextState = Branch;
						ClsJump:   nextState = Jump;
						default:   nextState = Fetch;
					endcase
				end
			end
			MemAddr:
				nextState = dec.isStore ? MemWrite : MemRead;
			MemRead:
				nextState = MemReady ? WriteBack : MemRead;
			MemWrite:
				nextState = MemReady ? Fetch : MemWrite;
			WriteBack:
				nextState = Fetch;
			ExecR:
				nextState = REnd;
			ExecI:
				nextState = IEnd;
			REnd, IEnd, Branch, Jump:
				nextState = trapReq ? Trap : Fetch;
			Trap:
				nextState = Fetch;
			default:
				nextState = Fetch;
		endcase
	end

endmodule

/* design/datapathCtrl.sv */
`include "ctrl_cfg.svh"

module datapathCtrl import ctrlPkg::*;
(
	input  ctrlStateT  state,
	decodeIf.consumer  dec,
	input  logic       MemReady,
	input  logic       AluZero,
	input  logic       trapIsInt,
	output logic       PcWrite,
	output logic [2:0] PcSource,
	output logic       IrWrite,
	output logic       RegWrite,
	output logic [1:0] RegDst,
	output logic [1:0] RfSource,
	output logic [3:0] AluOp,
	output logic       AluSrcA,
	output logic [1:0] AluSrcB,
	output logic       IorD,
	output logic       MemRw,
	output logic       MemSign,
	output logic [3:0] ByteEn
);

	logic [3:0] accessBe;

	always_comb
	begin
		case (dec.memSize)
			`SizeByte: accessBe = `BeByte;
			`SizeHalf: accessBe = `BeHalf;
			default:   accessBe = `BeWord;
		endcase
	end

	always_comb
	begin
		PcWrite = 1'b0;
		PcSource = '0;
		IrWrite = 1'b0;
		RegWrite = 1'b0;
		RegDst = '0;
		RfSource = '0;
		AluOp = '0;
		AluSrcA = 1'b0;
		AluSrcB = '0;
		IorD = 1'b0;
		MemRw = 1'b0;
		MemSign = 1'b0;
		ByteEn = '0;
		case (state)
			Fetch:
			begin
				ByteEn = `BeWord;
				AluSrcA = `SrcAPc;
				AluSrcB = `SrcBFour; // PC + 4
				AluOp = `AluAddu;
				PcSource = `PcSrcPc4;
				IrWrite = MemReady;
				PcWrite = MemReady; // only once the word arrives
			end
			Decode:
			begin
				AluSrcA = `SrcAPc;
				AluSrcB = `SrcBFourImm; // branch target ahead of time
				AluOp = `AluAdd;
			end
			MemAddr:
			begin
				AluSrcA = `SrcAReg;
				AluSrcB = `SrcBImm;
				AluOp = `AluAdd;
			end
			MemRead, MemWrite:
			begin
				IorD = 1'b1;
				ByteEn = accessBe;
				MemRw = (state == MemWrite);
				MemSign = (state == MemRead) && dec.memSigned;
			end
			WriteBack:
			begin
				RegWrite = 1'b1;
				RegDst = `RegDstRt;
				RfSource = `RfSrcMdr;
			end
			ExecR, ExecI:
			begin
				AluSrcA = `SrcAReg;
				AluSrcB = (state == ExecR) ? `SrcBReg : `SrcBImm;
				AluOp = dec.aluOp;
			end
			REnd, IEnd:
			begin
				RegWrite = 1'b1;
				RfSource = `RfSrcAlu;
				RegDst = (state == REnd) ? `RegDstRd : `RegDstRt;
			end
			Branch:
			begin
				AluSrcA = `SrcAReg;
				AluSrcB = `SrcBReg;
				AluOp = dec.aluOp;
				PcSource = `PcSrcBranch;
				PcWrite = (AluZero == dec.branchOnZero);
			end
			Jump:
			begin
				PcWrite = 1'b1;
				PcSource = dec.jumpReg ? `PcSrcReg : `PcSrcJump;
				if (dec.jumpLink)
				begin
					RegWrite = 1'b1;
					RfSource = `RfSrcPc;
					RegDst = dec.linkRd ? `RegDstRd : `RegDstRa;
				end
			end
			Trap:
			begin
				PcWrite = 1'b1;
				PcSource = trapIsInt ? `PcSrcInt : `PcSrcExc;
			end
			default: ;
		endcase
	end

endmodule

/* design/trapCtrl.sv */
`include "ctrl_cfg.svh"

module trapCtrl import ctrlPkg::*;
(
	input  logic       PClk,
	input  logic       Reset,
	input  ctrlStateT  state,
	decodeIf.consumer  dec,
	input  logic       AluOverflow,
	input  logic       ExtInt,
	input  logic       IE,
	output logic       trapReq,
	output logic       trapIsInt,
	output logic       Cp0Write,
	output logic       Exception,
	output logic [4:0] ExCode
);

	logic [4:0] cause;
	logic [4:0] causeNext;

	// Decode traps win over overflow, overflow over interrupt
	always_comb
	begin
		trapReq = 1'b0;
		causeNext = `ExcInt;
		if (state == Decode && dec.instrClass inside {ClsSyscall, ClsBreak, ClsIllegal})
		begin
			trapReq = 1'b1;
			case (dec.instrClass)
				ClsSyscall: causeNext = `ExcSyscall;
				ClsBreak:   causeNext = `ExcBreak;
				default:    causeNext = `ExcIllegal;
			endcase
		end
		else if ((state == REnd || state == IEnd) && AluOverflow && IE)
		begin
			trapReq = 1'b1;
			causeNext = `ExcOverflow;
		end
		else if (state inside {REnd, IEnd, Branch, Jump} && ExtInt && IE)
			trapReq = 1'b1;
	end

	always_ff @(posedge PClk or posedge Reset)
	begin
		if (Reset)
			cause <= `ExcInt;
		else if (trapReq)
			cause <= causeNext;
	end

	assign Exception = (state == Trap);
	assign Cp0Write = (state == Trap); // EPC and cause capture
	assign ExCode = (state == Trap) ? cause : 5'd0;
	assign trapIsInt = (state == Trap) && (cause == `ExcInt);

endmodule

/* design/multiCycleCtrl.sv */
module multiCycleCtrl import ctrlPkg::*;
(
	input  logic        PClk,
	input  logic        Reset,
	input  logic [31:0] Instr,
	input  logic        AluZero,
	input  logic        AluOverflow,
	input  logic        MemReady,
	input  logic        ExtInt,
	input  logic        IE,
	output logic        PcWrite,
	output logic [2:0]  PcSource,
	output logic        IrWrite,
	output logic        RegWrite,
	output logic [1:0]  RegDst,
	output logic [1:0]  RfSource,
	output logic [3:0]  AluOp,
	output logic        AluSrcA,
	output logic [1:0]  AluSrcB,
	output logic        IorD,
	output logic        MemRw,
	output logic        MemSign,
	output logic [3:0]  ByteEn,
	output logic        Cp0Write,
	output logic        Exception,
	output logic [4:0]  ExCode
);

	ctrlStateT state;
	logic trapReq;
	logic trapIsInt;

	decodeIf decBus();

	instrDecoder decoder (.Instr(Instr), .dec(decBus.decoder));

	ctrlSequencer sequencer (.PClk(PClk), .Reset(Reset), .MemReady(MemReady),
		.trapReq(trapReq), .dec(decBus.consumer), .state(state));

	datapathCtrl datapath (.state(state), .dec(decBus.consumer), .MemReady(MemReady),
		.AluZero(AluZero), .trapIsInt(trapIsInt), .PcWrite(PcWrite), .PcSource(PcSource),
		.IrWrite(IrWrite), .RegWrite(RegWrite), .RegDst(RegDst), .RfSource(RfSource),
		.AluOp(AluOp), .AluSrcA(AluSrcA), .AluSrcB(AluSrcB), .IorD(IorD), .MemRw(MemRw),
		.MemSign(MemSign), .ByteEn(ByteEn));

	trapCtrl traps (.PClk(PClk), .Reset(Reset), .state(state), .dec(decBus.consumer),
		.AluOverflow(AluOverflow), .ExtInt(ExtInt), .IE(IE), .trapReq(trapReq),
		.trapIsInt(trapIsInt), .Cp0Write(Cp0Write), .Exception(Exception), .ExCode(ExCode));

endmodule

/* tests/multiCycleCtrlTb.sv */
`include "ctrl_cfg.svh"

module multiCycleCtrlTb;

	localparam int ClkPeriod = 8;
	localparam int RandSeed = 36184;
	localparam int NumInstrs = 50;
	localparam int CyclesPerInstr = 12; // worst fetch wait plus memory wait
	localparam int TimeoutCycles = NumInstrs * CyclesPerInstr + 10;

	typedef struct packed
	{
		logic       pcWrite;
		logic [2:0] pcSource;
		logic       irWrite;
		logic       regWrite;
		logic [1:0] regDst;
		logic [1:0] rfSource;
		logic [3:0] aluOp;
		logic       aluSrcA;
		logic [1:0] aluSrcB;
		logic       iorD;
		logic       memRw;
		logic       memSign;
		logic [3:0] byteEn;
		logic       cp0Write;
		logic       exception;
		logic [4:0] exCode;
	} ctrlOutsT;

	logic PClk, Reset, AluZero, AluOverflow, MemReady, ExtInt, IE;
	logic [31:0] Instr;
	logic PcWrite, IrWrite, RegWrite, AluSrcA, IorD, MemRw, MemSign, Cp0Write, Exception;
	logic [2:0] PcSource;
	logic [1:0] RegDst, RfSource, AluSrcB;
	logic [3:0] AluOp, ByteEn;
	logic [4:0] ExCode;

	int errorCount = 0;
	int checkCount = 0;
	string fieldNames [16] = '{"PcWrite", "PcSource", "IrWrite", "RegWrite", "RegDst",
		"RfSource", "AluOp", "AluSrcA", "AluSrcB", "IorD", "MemRw", "MemSign", "ByteEn",
		"Cp0Write", "Exception", "ExCode"};
	int fieldWidths [16] = '{1, 3, 1, 1, 2, 2, 4, 1, 2, 1, 1, 1, 4, 1, 1, 5};

	multiCycleCtrl dut_i (.*);

	initial
	begin
		PClk = 1'b0;
		forever #(ClkPeriod / 2) PClk = ~PClk;
	end

	function automatic ctrlOutsT fetchOuts(input logic ready);
		ctrlOutsT o;
		o = '0;
		o.pcWrite = ready;
		o.irWrite = ready;
		o.byteEn = `BeWord;
		o.aluSrcA = `SrcAPc;
		o.aluSrcB = `SrcBFour;
		o.aluOp = `AluAddu;
		o.pcSource = `PcSrcPc4;
		return o;
	endfunction

	function automatic ctrlOutsT decodeOuts();
		ctrlOutsT o;
		o = '0;
		o.aluSrcA = `SrcAPc;
		o.aluSrcB = `SrcBFourImm;
		o.aluOp = `AluAdd;
		return o;
	endfunction

	function automatic ctrlOutsT execOuts(input logic [1:0] srcB, input logic [3:0] op);
		ctrlOutsT o;
		o = '0;
		o.aluSrcA = `SrcAReg;
		o.aluSrcB = srcB;
		o.aluOp = op;
		return o;
	endfunction

	function automatic ctrlOutsT writeOuts(input logic [1:0] dst, input logic [1:0] src);
		ctrlOutsT o;
		o = '0;
		o.regWrite = 1'b1;
		o.regDst = dst;
		o.rfSource = src;
		return o;
	endfunction

	function automatic ctrlOutsT trapOuts(input logic [4:0] code, input logic isInt);
		ctrlOutsT o;
		o = '0;
		o.pcWrite = 1'b1;
		o.pcSource = isInt ? `PcSrcInt : `PcSrcExc;
		o.exception = 1'b1;
		o.cp0Write = 1'b1;
		o.exCode = code;
		return o;
	endfunction

	// Walks the port fields from the MSB down
	task automatic compareOutputs(input string where, input ctrlOutsT exp);
		ctrlOutsT got;
		logic [30:0] gotBits;
		logic [30:0] expBits;
		logic [30:0] mask;
		int lsb;
		got = {PcWrite, PcSource, IrWrite, RegWrite, RegDst, RfSource, AluOp, AluSrcA,
			AluSrcB, IorD, MemRw, MemSign, ByteEn, Cp0Write, Exception, ExCode};
		gotBits = got;
		expBits = exp;
		lsb = 31;
		checkCount++;
		for (int i = 0; i < 16; i++)
		begin
			lsb = lsb - fieldWidths[i];
			mask = (31'd1 << fieldWidths[i]) - 31'd1;
			if (((gotBits >> lsb) & mask) !== ((expBits >> lsb) & mask))
			begin
				errorCount++;
				$display("CHECK FAILED %s %s got %h expected %h", where, fieldNames[i],
					(gotBits >> lsb) & mask, (expBits >> lsb) & mask);
			end
		end
	endtask

	task automatic stepCycle(input string where, input ctrlOutsT exp);
		@(negedge PClk); // outputs settled
		compareOutputs(where, exp);
		@(posedge PClk);
	endtask

	task automatic fetchWord(input logic [31:0] word);
		int waits;
		waits = $urandom_range(3, 1);
		MemReady <= 1'b0;
		repeat (waits) stepCycle("Fetch wait", fetchOuts(1'b0));
		MemReady <= 1'b1;
		Instr <= word;
		stepCycle("Fetch ready", fetchOuts(1'b1));
		MemReady <= 1'b0;
		stepCycle("Decode", decodeOuts());
	endtask

	task automatic resetAndFetch();
		@(posedge PClk);
		repeat (2) stepCycle("Reset", fetchOuts(1'b0));
		Reset <= 1'b0;
		repeat (2) stepCycle("Idle fetch", fetchOuts(1'b0));
		fetchWord(32'h0);
	endtask

	task automatic aluInstructions();
		logic [5:0] immOps [8] = '{`OpAddi, `OpAddiu, `OpSlti, `OpSltiu, `OpAndi, `OpOri,
			`OpXori, `OpLui};
		logic [3:0] immAlu [8] = '{`AluAdd, `AluAddu, `AluSlt, `AluSltu, `AluAnd, `AluOr,
			`AluXor, `AluLu};
		logic [3:0] rAlu [12] = '{`AluAddu, `AluAdd, `AluSubu, `AluSub, `AluAnd, `AluOr,
			`AluNor, `AluXor, `AluSltu, `AluSlt, `AluSlet, `AluLu}; // funct 1 to 12
		logic [31:0] word;
		int idx;
		repeat (6)
		begin
			idx = $urandom_range(11, 0);
			word = $urandom;
			word[31:26] = `OpRType;
			word[5:0] = 6'(idx + 1);
			fetchWord(word);
			stepCycle("ExecR", execOuts(`SrcBReg, rAlu[idx]));
			stepCycle("REnd", writeOuts(`RegDstRd, `RfSrcAlu));
		end
		for (int k = 0; k < 8; k++)
		begin
			word = $urandom;
			word[31:26] = immOps[k];
			fetchWord(word);
			stepCycle("ExecI", execOuts(`SrcBImm, immAlu[k]));
			stepCycle("IEnd", writeOuts(`RegDstRt, `RfSrcAlu));
		end
		fetchWord(32'h0); // Decode straight back to Fetch
	endtask

	task automatic memoryAccesses();
		logic [5:0] memOps [8] = '{`OpLb, `OpLbs, `OpLh, `OpLhs, `OpLw, `OpSb, `OpSh, `OpSw};
		logic [3:0] memBe [8] = '{`BeByte, `BeByte, `BeHalf, `BeHalf, `BeWord, `BeByte,
			`BeHalf, `BeWord};
		logic [31:0] word;
		ctrlOutsT access;
		logic store;
		int waits;
		string where;
		for (int k = 0; k < 8; k++)
		begin
			store = (k >= 5);
			if (store)
				where = "MemWrite";
			else
				where = "MemRead";
			word = $urandom;
			word[31:26] = memOps[k];
			fetchWord(word);
			stepCycle("MemAddr", execOuts(`SrcBImm, `AluAdd));
			access = '0;
			access.iorD = 1'b1;
			access.byteEn = memBe[k];
			access.memRw = store;
			access.memSign = (k == 1 || k == 3); // lbs, lhs
			waits = $urandom_range(3, 0);
			repeat (waits) stepCycle(where, access);
			MemReady <= 1'b1;
			stepCycle(where, access);
			MemReady <= 1'b0;
			if (!store)
				stepCycle("WriteBack", writeOuts(`RegDstRt, `RfSrcMdr));
		end
	endtask

	task automatic branchesAndJumps();
		logic [5:0] brOps [6] = '{`OpBeq, `OpBgez, `OpBgtz, `OpBltz, `OpBlez, `OpBne};
		logic [3:0] brAlu [6] = '{`AluSubu, `AluSlt, `AluSlet, `AluSlt, `AluSlet, `AluSubu};
		logic brOnZero [6] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
		logic [5:0] jOps [4] = '{`OpJ, `OpJal, `OpJr, `OpJalr};
		logic [31:0] word;
		logic zero;
		ctrlOutsT exp;
		for (int k = 0; k < 6; k++)
		begin
			for (int z = 0; z < 2; z++)
			begin
				zero = (z == 1);
				word = $urandom;
				word[31:26] = brOps[k];
				fetchWord(word);
				AluZero <= zero;
				exp = execOuts(`SrcBReg, brAlu[k]);
				exp.pcSource = `PcSrcBranch;
				exp.pcWrite = (zero == brOnZero[k]);
				stepCycle("Branch", exp);
				AluZero <= 1'b0;
			end
		end
		for (int k = 0; k < 4; k++)
		begin
			word = $urandom;
			word[31:26] = jOps[k];
			fetchWord(word);
			exp = '0;
			exp.pcWrite = 1'b1;
			exp.pcSource = (k >= 2) ? `PcSrcReg : `PcSrcJump;
			if (k % 2 == 1)
			begin
				exp.regWrite = 1'b1;
				exp.rfSource = `RfSrcPc;
				exp.regDst = (k == 3) ? `RegDstRd : `RegDstRa; // jalr links to rd
			end
			stepCycle("Jump", exp);
		end
	endtask

	task automatic decodeTrap(input logic [5:0] op, input logic [5:0] funct,
		input logic [4:0] code);
		logic [31:0] word;
		word = $urandom;
		word[31:26] = op;
		word[5:0] = funct;
		fetchWord(word);
		stepCycle("Trap", trapOuts(code, 1'b0));
	endtask

	task automatic trapCases();
		ctrlOutsT exp;
		decodeTrap(`OpSpecial, `FnSyscall, 5'd8);
		decodeTrap(`OpSpecial, `FnBreak, 5'd9);
		decodeTrap(6'b011101, 6'($urandom), 5'd10);
		decodeTrap({3'b010, 3'($urandom)}, 6'($urandom), 5'd10); // old coprocessor class
		for (int en = 1; en >= 0; en--)
		begin
			IE <= (en == 1);
			fetchWord({6'b0, 20'($urandom), 6'd2});
			stepCycle("ExecR", execOuts(`SrcBReg, `AluAdd));
			AluOverflow <= 1'b1;
			stepCycle("REnd", writeOuts(`RegDstRd, `RfSrcAlu));
			AluOverflow <= 1'b0;
			if (en == 1)
				stepCycle("Overflow trap", trapOuts(5'd12, 1'b0));
			else
				stepCycle("Fetch after REnd", fetchOuts(1'b0));
			fetchWord({`OpBeq, 26'($urandom)});
			ExtInt <= 1'b1;
			exp = execOuts(`SrcBReg, `AluSubu);
			exp.pcSource = `PcSrcBranch; // beq not taken while AluZero is low
			stepCycle("Branch", exp);
			ExtInt <= 1'b0;
			if (en == 1)
				stepCycle("Interrupt trap", trapOuts(5'd0, 1'b1));
			else
				stepCycle("Fetch after Branch", fetchOuts(1'b0));
		end
	endtask

	task automatic summarize();
		$display("Summary: %0d cycle checks, %0d errors", checkCount, errorCount);
	endtask

	initial
	begin
		#(TimeoutCycles * ClkPeriod);
		$display("Timeout: tests did not finish within %0d cycles", TimeoutCycles);
		summarize();
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		void'($urandom(RandSeed));
		Reset <= 1'b1;
		Instr <= 32'h0;
		AluZero <= 1'b0;
		AluOverflow <= 1'b0;
		MemReady <= 1'b0;
		ExtInt <= 1'b0;
		IE <= 1'b0;
		resetAndFetch();
		aluInstructions();
		memoryAccesses();
		branchesAndJumps();
		trapCases();
		fetchWord(32'h0);
		summarize();
		if (errorCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* multiCycleCtrl.f */
+incdir+design
design/ctrlPkg.sv
design/decodeIf.sv
design/instrDecoder.sv
design/ctrlSequencer.sv
design/datapathCtrl.sv
design/trapCtrl.sv
design/multiCycleCtrl.sv
tests/multiCycleCtrlTb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f multiCycleCtrl.f --top-module multiCycleCtrlTb -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -q "Verification passed" \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation did not pass"; exit 1; }
